//--- Makefile
# Verilator build and run of the APB slice testbench

TOP         ?= apb_slice_tb
WAIT_STATES ?= 1
COUNT_WIDTH ?= 16
SEED        ?= 24
VERILATOR   ?= verilator
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log

FILELIST := apb_slice_top.f
SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD_DIR)/V$(TOP)

VFLAGS ?= --binary --timing --assert -Wno-fatal
PARAMS := -Gwait_states=$(WAIT_STATES) -Gcount_width=$(COUNT_WIDTH) -Gseed=$(SEED)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(PARAMS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'sim passed' $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- apb_slice_top.f
design/apb_slice_pkg.sv
design/apb_requester.sv
design/apb_timing_slice.sv
design/apb_csr_block.sv
design/event_counter.sv
design/apb_slice_top.sv
testbench/apb_slice_tb.sv

//--- design/apb_csr_block.sv
`default_nettype none

module apb_csr_block #(
  parameter int wait_states = 1,
  parameter int count_width = 16
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  apb_slice_pkg::apb_req_t     req,
  output apb_slice_pkg::apb_rsp_t     rsp,
  output logic                        count_enable,
  output logic                        count_load,
  output logic [count_width-1:0]      count_load_value,
  input  wire logic [count_width-1:0] count_value
);

  logic [2:0]  wait_cnt;
  logic        complete_q;
  logic        access;
  logic        ready;
  logic        addr_err;
  logic        commit_write;
  logic [31:0] read_value;
  logic [31:0] scratch_q;
  logic [31:0] ctrl_q;

  // Lane by lane merge of new write data into an old register value
  function automatic logic [31:0] merge_lanes(
    input logic [31:0] old_value,
    input logic [31:0] new_value,
    input logic [3:0]  strb
  );
    logic [31:0] result;
    result = old_value;
    for (int lane = 0; lane < 4; lane++) begin
      if (strb[lane]) begin
        result[lane*8 +: 8] = new_value[lane*8 +: 8];
      end
    end
    return result;
  endfunction

  // --------------------------------------------------------------------------
  // Wait state pacing
  // --------------------------------------------------------------------------

  // Once a transfer has completed the bus is ignored until psel falls,
  // since the slice keeps the old access visible for one more cycle
  assign access = req.psel && req.penable && !complete_q;
  assign ready  = access && (wait_cnt == 3'(wait_states));

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt   <= 3'd0;
      complete_q <= 1'b0;
    end else begin
      if (!req.psel) begin
        complete_q <= 1'b0;
      end else if (ready) begin
        complete_q <= 1'b1;
      end
      // Count access cycles until the programmed number of wait states
      if (ready || !access) begin
        wait_cnt <= 3'd0;
      end else begin
        wait_cnt <= wait_cnt + 3'd1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------

  always_comb begin
    addr_err   = 1'b0;
    read_value = 32'h0;
    case (req.paddr)
      apb_slice_pkg::reg_id: begin
        read_value = apb_slice_pkg::csr_id_value;
        // ID is read only
        addr_err   = req.pwrite;
      end
      apb_slice_pkg::reg_scratch: read_value = scratch_q;
      apb_slice_pkg::reg_ctrl:    read_value = ctrl_q;
      apb_slice_pkg::reg_count:   read_value = 32'(count_value);
      default:                    addr_err   = 1'b1;
    endcase
  end

  assign commit_write = ready && req.pwrite && !addr_err;

  // Errors and writes return zero data
  assign rsp.prdata  = (req.pwrite || addr_err) ? 32'h0 : read_value;
  assign rsp.pready  = ready;
  assign rsp.pslverr = ready && addr_err;

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      scratch_q <= 32'h0;
      ctrl_q    <= 32'h0;
    end else if (commit_write) begin
      if (req.paddr == apb_slice_pkg::reg_scratch) begin
        scratch_q <= merge_lanes(scratch_q, req.pwdata, req.pstrb);
      end
      if (req.paddr == apb_slice_pkg::reg_ctrl) begin
        ctrl_q <= merge_lanes(ctrl_q, req.pwdata, req.pstrb);
      end
    end
  end

  // Counter steering; the load lands on the same edge as the write commit
  assign count_enable     = ctrl_q[0];
  assign count_load       = commit_write && (req.paddr == apb_slice_pkg::reg_count);
  assign count_load_value = req.pwdata[count_width-1:0];

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Ready only inside an access phase that followed a setup cycle
  a_ready_in_access: assert property (@(posedge clk) disable iff (rst)
    rsp.pready |-> req.penable && $past(req.psel))
    else $error("pready outside access phase");

endmodule

`default_nettype wire

//--- design/apb_requester.sv
`default_nettype none

module apb_requester (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    cmd_valid,
  input  apb_slice_pkg::apb_cmd_t      cmd,
  output logic                         busy,
  output logic                         done,
  output logic [31:0]                  rdata,
  output logic                         slverr,
  output apb_slice_pkg::apb_req_t      req,
  input  apb_slice_pkg::apb_rsp_t      rsp
);

  apb_slice_pkg::req_state_e state;
  apb_slice_pkg::req_state_e state_next;

  // Command held for the whole transfer
  apb_slice_pkg::apb_cmd_t cmd_q;

  logic accept;
  logic finish;

  // Only an idle requester takes a command, so strobes during busy are dropped
  assign accept = cmd_valid && (state == apb_slice_pkg::st_idle);

  // pready only counts while the access phase is being driven
  assign finish = (state == apb_slice_pkg::st_access) && rsp.pready;

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      apb_slice_pkg::st_idle: begin
        if (accept) begin
          state_next = apb_slice_pkg::st_setup;
        end
      end
      // Setup always lasts exactly one cycle
      apb_slice_pkg::st_setup: state_next = apb_slice_pkg::st_access;
      apb_slice_pkg::st_access: begin
        if (finish) begin
          state_next = apb_slice_pkg::st_done;
        end
      end
      // Done drops psel for a cycle before the next transfer can start
      default: state_next = apb_slice_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= apb_slice_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Payload capture on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  // Response capture, held until the next done
  always_ff @(posedge clk) begin
    if (finish) begin
      rdata <= rsp.prdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slverr <= 1'b0;
    end else if (finish) begin
      slverr <= rsp.pslverr;
    end
  end

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------

  assign busy = (state != apb_slice_pkg::st_idle);
  assign done = (state == apb_slice_pkg::st_done);

  always_comb begin
    req.paddr   = cmd_q.addr;
    req.psel    = (state == apb_slice_pkg::st_setup) || (state == apb_slice_pkg::st_access);
    req.penable = (state == apb_slice_pkg::st_access);
    req.pprot   = cmd_q.prot;
    // Strobes are driven low on reads as APB4 requires
    req.pstrb   = cmd_q.write ? cmd_q.strb : 4'h0;
    req.pwrite  = cmd_q.write;
    req.pwdata  = cmd_q.wdata;
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  a_penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
    req.penable |-> req.psel)
    else $error("penable high without psel");

  // A stalled access phase must keep every request field still
  a_access_stable: assert property (@(posedge clk) disable iff (rst)
    (req.psel && req.penable && !rsp.pready) |=> $stable(req))
    else $error("request changed during access phase");

endmodule

`default_nettype wire

//--- design/apb_slice_pkg.sv
`default_nettype none

package apb_slice_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------

  // Fixed so that the structs below have a fixed width
  localparam int apb_addr_width = 12;
  localparam int apb_prot_width = 3;

  // Value returned by a read of the ID register
  localparam logic [31:0] csr_id_value = 32'h5A1C_0001;

  // --------------------------------------------------------------------------
  // Bus structs
  // --------------------------------------------------------------------------

  // Requester to target direction
  typedef struct packed {
    logic [apb_addr_width-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic [apb_prot_width-1:0] pprot;
    logic [3:0]                pstrb;
    logic                      pwrite;
    logic [31:0]               pwdata;
  } apb_req_t;

  // Target to requester direction
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // One command as presented on the command port
  typedef struct packed {
    logic [apb_addr_width-1:0] addr;
    logic                      write;
    logic [31:0]               wdata;
    logic [3:0]                strb;
    logic [apb_prot_width-1:0] prot;
  } apb_cmd_t;

  // --------------------------------------------------------------------------
  // Enums
  // --------------------------------------------------------------------------

  // Requester FSM states
  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access,
    st_done
  } req_state_e;

  // Register offsets of the CSR target
  typedef enum logic [apb_addr_width-1:0] {
    reg_id      = 12'h000,
    reg_scratch = 12'h004,
    reg_ctrl    = 12'h008,
    reg_count   = 12'h00C
  } csr_reg_e;

endpackage

`default_nettype wire

//--- design/apb_slice_top.sv
`default_nettype none

module apb_slice_top #(
  parameter int wait_states = 1,
  parameter int count_width = 16
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               cmd_valid,
  input  apb_slice_pkg::apb_cmd_t cmd,
  output logic                    busy,
  output logic                    done,
  output logic [31:0]             rdata,
  output logic                    slverr,
  input  wire logic               tick
);

  // Requester side of the slice
  apb_slice_pkg::apb_req_t up_req;
  apb_slice_pkg::apb_rsp_t up_rsp;

  // Target side of the slice
  apb_slice_pkg::apb_req_t dn_req;
  apb_slice_pkg::apb_rsp_t dn_rsp;

  // Counter steering from the target
  logic                   count_enable;
  logic                   count_load;
  logic [count_width-1:0] count_load_value;
  logic [count_width-1:0] count_value;

  // --------------------------------------------------------------------------
  // Instances
  // --------------------------------------------------------------------------

  apb_requester requester_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .done      (done),
    .rdata     (rdata),
    .slverr    (slverr),
    .req       (up_req),
    .rsp       (up_rsp)
  );

  // One cycle of register on both directions between requester and target
  apb_timing_slice timing_slice_i (
    .clk     (clk),
    .rst     (rst),
    .req_in  (up_req),
    .rsp_out (up_rsp),
    .req_out (dn_req),
    .rsp_in  (dn_rsp)
  );

  apb_csr_block #(
    .wait_states (wait_states),
    .count_width (count_width)
  ) csr_block_i (
    .clk              (clk),
    .rst              (rst),
    .req              (dn_req),
    .rsp              (dn_rsp),
    .count_enable     (count_enable),
    .count_load       (count_load),
    .count_load_value (count_load_value),
    .count_value      (count_value)
  );

  event_counter #(
    .count_width (count_width)
  ) event_counter_i (
    .clk        (clk),
    .rst        (rst),
    .enable     (count_enable),
    .tick       (tick),
    .load       (count_load),
    .load_value (count_load_value),
    .count      (count_value)
  );

endmodule

`default_nettype wire

//--- design/apb_timing_slice.sv
`default_nettype none

module apb_timing_slice (
  input  wire logic               clk,
  input  wire logic               rst,
  // Upstream side, facing the requester
  input  apb_slice_pkg::apb_req_t req_in,
  output apb_slice_pkg::apb_rsp_t rsp_out,
  // Downstream side, facing the target
  output apb_slice_pkg::apb_req_t req_out,
  input  apb_slice_pkg::apb_rsp_t rsp_in
);

  logic pready_next;

  // --------------------------------------------------------------------------
  // Request path
  // --------------------------------------------------------------------------

  // All fields move one cycle; only psel and penable need a known reset value
  always_ff @(posedge clk) begin
    req_out <= req_in;
    if (rst) begin
      req_out.psel    <= 1'b0;
      req_out.penable <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Response path
  // --------------------------------------------------------------------------

  // The target sees psel and penable a cycle late, so its pready is only
  // forwarded when it belongs to a delayed transfer that is really in its
  // access phase. A ready left over from an idle bus never reaches upstream
  assign pready_next = req_out.psel && req_out.penable && rsp_in.pready;

  always_ff @(posedge clk) begin
    rsp_out.prdata  <= rsp_in.prdata;
    rsp_out.pslverr <= rsp_in.pslverr;
    rsp_out.pready  <= pready_next;
    if (rst) begin
      rsp_out.pready  <= 1'b0;
      rsp_out.pslverr <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Upstream ready always traces back to a downstream select one cycle earlier
  a_ready_after_select: assert property (@(posedge clk) disable iff (rst)
    rsp_out.pready |-> $past(req_out.psel))
    else $error("pready_out without prior psel_out");

endmodule

`default_nettype wire

//--- design/event_counter.sv
`default_nettype none

module event_counter #(
  parameter int count_width = 16
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   enable,
  input  wire logic                   tick,
  input  wire logic                   load,
  input  wire logic [count_width-1:0] load_value,
  output logic [count_width-1:0]      count
);

  // --------------------------------------------------------------------------
  // Counter
  // --------------------------------------------------------------------------

  // A load wins over a tick in the same cycle.
  // The increment wraps at 2**count_width by natural overflow
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (enable && tick) begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- testbench/apb_slice_tb.sv
`default_nettype none

module apb_slice_tb;
  timeunit 1ns;
  timeprecision 1ps;

  parameter int wait_states = 1;
  parameter int count_width = 16;
  parameter int seed = 24;

  // Upper bound on the commands that the tests below issue
  localparam int num_cmds = 32;
  localparam int timeout_cycles = num_cmds * (wait_states + 8) + 2000;
  // A single command gets this many cycles before it counts as lost
  localparam int done_limit = wait_states + 20;

  logic                    clk;
  logic                    rst;
  logic                    cmd_valid;
  apb_slice_pkg::apb_cmd_t cmd;
  logic                    busy;
  logic                    done;
  logic [31:0]             rdata;
  logic                    slverr;
  logic                    tick;

  int          seed_var;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          cycle;
  int          accept_cycle;
  logic        outstanding;
  logic [31:0] exp_rdata;
  logic        exp_check_rdata;
  logic        exp_slverr;
  logic [31:0] scratch_model;
  logic [63:0] count_mask;

  apb_slice_top #(
    .wait_states (wait_states),
    .count_width (count_width)
  ) apb_slice_top_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .done      (done),
    .rdata     (rdata),
    .slverr    (slverr),
    .tick      (tick)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Reference model of the command port
  // --------------------------------------------------------------------------

  // A command is taken when the strobe meets an idle requester, and the
  // transfer stays open until its done pulse
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (rst) begin
      outstanding <= 1'b0;
    end else if (cmd_valid && !outstanding) begin
      outstanding  <= 1'b1;
      accept_cycle <= cycle;
    end else if (done) begin
      outstanding <= 1'b0;
    end
  end

  // Byte lane mask built from the write strobes
  function automatic logic [31:0] lane_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> (!busy && !done))
    else begin
      errors++;
      $display("busy or done was high in the first cycle after reset");
    end

  a_rdata: assert property (@(posedge clk) disable iff (rst)
    (done && exp_check_rdata) |-> (rdata == exp_rdata))
    else begin
      errors++;
      $display("ERR %0t rdata got 0x%h exp 0x%h", $time, $sampled(rdata),
               $sampled(exp_rdata));
    end

  a_slverr: assert property (@(posedge clk) disable iff (rst)
    done |-> (slverr == exp_slverr))
    else begin
      errors++;
      $display("ERR %0t slverr got %0b exp %0b", $time, $sampled(slverr),
               $sampled(exp_slverr));
    end

  // Done lands wait_states+5 edges after the accepting edge
  a_latency: assert property (@(posedge clk) disable iff (rst)
    done |-> (cycle - accept_cycle == wait_states + 5))
    else begin
      errors++;
      $display("ERR %0t done latency got %0d exp %0d", $time,
               $sampled(cycle) - $sampled(accept_cycle), wait_states + 5);
    end

  a_busy_window: assert property (@(posedge clk) disable iff (rst)
    busy == outstanding)
    else begin
      errors++;
      $display("ERR %0t busy got %0b exp %0b", $time, $sampled(busy),
               $sampled(outstanding));
    end

  // A strobe during busy must not lead to a second done
  a_no_extra_done: assert property (@(posedge clk) disable iff (rst)
    done |-> outstanding)
    else begin
      errors++;
      $display("done pulsed at %0t without an accepted command", $time);
    end

  // --------------------------------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------------------------------

  // Issues one command and waits for its done pulse.
  // With decoy set, a second strobe is sent while the first one is busy
  task automatic run_cmd(input logic [11:0] addr, input logic write,
                         input logic [31:0] wdata, input logic [3:0] strb,
                         input logic [31:0] rd_exp, input logic chk_rd,
                         input logic err_exp, input logic decoy);
    int waited;
    logic [31:0] rnd;
    waited          = 0;
    rnd             = $random(seed_var);
    exp_rdata       = rd_exp;
    exp_check_rdata = chk_rd;
    exp_slverr      = err_exp;
    @(posedge clk);
    cmd_valid  <= 1'b1;
    cmd.addr   <= addr;
    cmd.write  <= write;
    cmd.wdata  <= wdata;
    cmd.strb   <= strb;
    cmd.prot   <= rnd[2:0];
    @(posedge clk);
    cmd_valid <= 1'b0;
    while (!done && waited < done_limit) begin
      @(posedge clk);
      waited++;
      cmd_valid <= decoy && (waited == 2);
      if (decoy && waited == 2) begin
        // This write would change scratch if it were taken
        cmd.addr  <= apb_slice_pkg::reg_scratch;
        cmd.write <= 1'b1;
        cmd.wdata <= ~scratch_model;
        cmd.strb  <= 4'hf;
      end
    end
    if (!done) begin
      errors++;
      $display("command to 0x%h got no done within %0d cycles", addr, done_limit);
    end
  endtask

  task automatic pulse_ticks(input int n);
    repeat (n) begin
      @(posedge clk);
      tick <= 1'b1;
    end
    @(posedge clk);
    tick <= 1'b0;
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %-22s ok", name);
    end else begin
      tests_failed++;
      $display("test %-22s FAILED with %0d errors", name, errors - errs_before);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    int          errs_before;
    int          n_ticks;
    logic [31:0] rnd;
    logic [31:0] wdata;
    logic [11:0] bad_addr;
    seed_var     = seed;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle        = 0;
    accept_cycle = 0;
    rst          = 1'b1;
    cmd_valid    = 1'b0;
    cmd          = '0;
    tick         = 1'b0;
    count_mask   = (64'h1 << count_width) - 64'h1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    errs_before = errors;
    run_cmd(apb_slice_pkg::reg_id, 1'b0, 32'h0, 4'h0, apb_slice_pkg::csr_id_value,
            1'b1, 1'b0, 1'b0);
    end_test("reset and id read", errs_before);

    // Scratch starts at zero and takes only the strobed lanes of each write
    errs_before   = errors;
    scratch_model = 32'h0;
    for (int i = 0; i < 8; i++) begin
      wdata = $random(seed_var);
      rnd   = $random(seed_var);
      run_cmd(apb_slice_pkg::reg_scratch, 1'b1, wdata, rnd[3:0], 32'h0, 1'b0, 1'b0, 1'b0);
      scratch_model = (scratch_model & ~lane_mask(rnd[3:0])) | (wdata & lane_mask(rnd[3:0]));
      run_cmd(apb_slice_pkg::reg_scratch, 1'b0, 32'h0, 4'h0, scratch_model, 1'b1, 1'b0, 1'b0);
    end
    end_test("scratch byte strobes", errs_before);

    // Bit 8 keeps the address clear of the four mapped offsets
    errs_before = errors;
    rnd         = $random(seed_var);
    bad_addr    = 12'h100 | (rnd[11:0] & 12'h0fc);
    run_cmd(bad_addr, 1'b0, 32'h0, 4'h0, 32'h0, 1'b1, 1'b1, 1'b0);
    rnd = $random(seed_var);
    run_cmd(apb_slice_pkg::reg_id, 1'b1, rnd, 4'hf, 32'h0, 1'b0, 1'b1, 1'b0);
    run_cmd(apb_slice_pkg::reg_id, 1'b0, 32'h0, 4'h0, apb_slice_pkg::csr_id_value,
            1'b1, 1'b0, 1'b0);
    end_test("error responses", errs_before);

    errs_before = errors;
    run_cmd(apb_slice_pkg::reg_scratch, 1'b0, 32'h0, 4'h0, scratch_model, 1'b1, 1'b0, 1'b1);
    repeat (4) @(posedge clk);
    run_cmd(apb_slice_pkg::reg_scratch, 1'b0, 32'h0, 4'h0, scratch_model, 1'b1, 1'b0, 1'b0);
    run_cmd(apb_slice_pkg::reg_id, 1'b0, 32'h0, 4'h0, apb_slice_pkg::csr_id_value,
            1'b1, 1'b0, 1'b0);
    end_test("latency and busy strobe", errs_before);

    // Control bit 0 is still clear here, so ticks must not count
    errs_before = errors;
    pulse_ticks(20);
    run_cmd(apb_slice_pkg::reg_count, 1'b0, 32'h0, 4'h0, 32'h0, 1'b1, 1'b0, 1'b0);
    run_cmd(apb_slice_pkg::reg_ctrl, 1'b1, 32'h1, 4'hf, 32'h0, 1'b0, 1'b0, 1'b0);
    rnd     = $random(seed_var);
    n_ticks = int'(rnd[7:0]) + 1;
    pulse_ticks(n_ticks);
    run_cmd(apb_slice_pkg::reg_count, 1'b0, 32'h0, 4'h0, 32'(n_ticks) & count_mask[31:0],
            1'b1, 1'b0, 1'b0);
    wdata = $random(seed_var);
    run_cmd(apb_slice_pkg::reg_count, 1'b1, wdata, 4'hf, 32'h0, 1'b0, 1'b0, 1'b0);
    run_cmd(apb_slice_pkg::reg_count, 1'b0, 32'h0, 4'h0, wdata & count_mask[31:0],
            1'b1, 1'b0, 1'b0);
    run_cmd(apb_slice_pkg::reg_ctrl, 1'b1, 32'h0, 4'hf, 32'h0, 1'b0, 1'b0, 1'b0);
    end_test("event counter", errs_before);

    repeat (4) @(posedge clk);
    $display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed,
             tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Ends a run that stalls somewhere in the sequence
  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
